//--- src.f
design/uart_cfg_pkg.sv
design/uart_reg_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart.sv
tb/uart_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module uart_tb -f src.f -o uart_tb_sim

# The log decides the result, so a fatal exit must not stop the script here
./obj_dir/uart_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

//--- tb/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

   localparam int clk_half    = 2;  // 4 ns period
   localparam int reset_len   = 10;
   localparam int n_tx        = 8;
   localparam int n_loop      = 4;
   localparam int frame_bits  = 10;
   localparam int total_frames = n_tx + n_loop + 2 + 2;
   localparam int watchdog_cycles =
      reset_len + total_frames * 20 * frame_bits * uart_cfg_pkg::baud_div;

   localparam uart_reg_pkg::word_t ready_w =
      uart_reg_pkg::word_t'(1) << uart_reg_pkg::st_tx_ready;
   localparam uart_reg_pkg::word_t en_w =
      uart_reg_pkg::word_t'(1) << uart_reg_pkg::st_rx_en;
   localparam uart_reg_pkg::word_t err_w =
      uart_reg_pkg::word_t'(1) << uart_reg_pkg::st_rx_err;

   logic                clk;
   logic                arst_n;
   logic                write_en;
   logic                addr;
   uart_reg_pkg::word_t write_val;
   uart_reg_pkg::word_t read_val;
   logic                tx_pin;
   logic                rx_pin;
   logic                drv_pin;   // Bit-banged serial source
   logic                loopback;  // 1 routes tx_pin back to rx_pin

   integer              seed = 32'hde50747b;
   int                  cycle = 0;
   int                  n_sent = 0;
   int                  frames_checked = 0;
   string               test_name = "reset";

   logic [9:0]          frame_q[$];  // Frames seen on tx_pin
   int                  start_q[$];  // Start cycle of each frame
   uart_cfg_pkg::byte_t sent_q[$];

   assign rx_pin = loopback ? tx_pin : drv_pin;

   uart dut_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .write_en  (write_en),
      .addr      (addr),
      .write_val (write_val),
      .read_val  (read_val),
      .tx_pin    (tx_pin),
      .rx_pin    (rx_pin)
   );

   always #(clk_half) clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   // 8N1 frame with the start bit in bit 0
   function automatic logic [9:0] frame_of(input uart_cfg_pkg::byte_t b);
      return {1'b1, b, 1'b0};
   endfunction

   task automatic abort_run();
      $display("Test FAILED");
      $fatal(1, "stopping on first failure");
   endtask

   task automatic check_word(input string what, input uart_reg_pkg::word_t exp,
                             input uart_reg_pkg::word_t act);
      if (act !== exp) begin
         $display("error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_byte(input string what, input uart_cfg_pkg::byte_t exp,
                             input uart_cfg_pkg::byte_t act);
      if (act !== exp) begin
         $display("error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic write_reg(input logic a, input uart_reg_pkg::word_t v);
      @(posedge clk);
      write_en  <= 1'b1;
      addr      <= a;
      write_val <= v;
      @(posedge clk);
      write_en  <= 1'b0;
   endtask

   task automatic read_reg(input logic a, output uart_reg_pkg::word_t v);
      @(posedge clk);
      addr <= a;
      @(negedge clk);
      v = read_val;  // Combinational read has settled by now
   endtask

   task automatic wait_status(input int pos, input logic val);
      uart_reg_pkg::word_t v;
      read_reg(uart_reg_pkg::addr_status, v);
      while (v[pos] !== val) begin
         read_reg(uart_reg_pkg::addr_status, v);
      end
   endtask

   task automatic send_byte(input uart_cfg_pkg::byte_t b);
      wait_status(uart_reg_pkg::st_tx_ready, 1'b1);
      write_reg(uart_reg_pkg::addr_data, uart_reg_pkg::word_t'(b));
      sent_q.push_back(b);
      n_sent++;
   endtask

   task automatic wait_frames(input int n);
      while (frames_checked < n) begin
         @(posedge clk);
      end
   endtask

   task automatic drive_frame(input uart_cfg_pkg::byte_t b, input logic stop);
      logic [9:0] bits;
      bits    = frame_of(b);
      bits[9] = stop;
      for (int i = 0; i < frame_bits; i++) begin
         @(posedge clk);
         drv_pin <= bits[i];
         repeat (uart_cfg_pkg::baud_div - 1) @(posedge clk);
      end
      @(posedge clk);
      drv_pin <= 1'b1;
      repeat (2 * uart_cfg_pkg::baud_div) @(posedge clk);  // Idle line
   endtask

   // Samples tx_pin near mid-bit relative to the falling start edge
   initial begin : tx_monitor
      logic [9:0] frame;
      int         start_at;
      forever begin
         @(negedge clk);
         if (arst_n === 1'b1 && tx_pin === 1'b0) begin
            start_at = cycle;
            repeat (uart_cfg_pkg::half_baud_div - 1) @(negedge clk);
            frame[0] = tx_pin;
            for (int i = 1; i < frame_bits; i++) begin
               repeat (uart_cfg_pkg::baud_div) @(negedge clk);
               frame[i] = tx_pin;
            end
            frame_q.push_back(frame);
            start_q.push_back(start_at);
         end
      end
   end

   initial begin : frame_checker
      logic [9:0]          seen;
      uart_cfg_pkg::byte_t sent;
      forever begin
         @(posedge clk);
         if (frame_q.size() > 0) begin
            seen = frame_q.pop_front();
            if (sent_q.size() == 0) begin
               $display("A frame appeared on tx_pin without a byte written to the DUT");
               abort_run();
            end else begin
               sent = sent_q.pop_front();
               check_word("tx frame", uart_reg_pkg::word_t'(frame_of(sent)),
                          uart_reg_pkg::word_t'(seen));
               frames_checked++;
            end
         end
      end
   end

   initial begin : watchdog
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
      abort_run();
   end

   initial begin : test_seq
      uart_reg_pkg::word_t v;
      uart_cfg_pkg::byte_t b;
      uart_cfg_pkg::byte_t b2;
      uart_cfg_pkg::byte_t last_rx;
      int                  first;
      int                  gap;

      clk       = 1'b0;
      arst_n    = 1'b0;
      write_en  = 1'b0;
      addr      = 1'b0;
      write_val = '0;
      drv_pin   = 1'b1;
      loopback  = 1'b1;
      repeat (reset_len) @(posedge clk);
      arst_n <= 1'b1;

      read_reg(uart_reg_pkg::addr_status, v);
      check_word("status after reset", ready_w, v);
      for (int i = 0; i < 2 * uart_cfg_pkg::baud_div; i++) begin
         @(negedge clk);
         check_word("idle tx_pin", uart_reg_pkg::word_t'(1), uart_reg_pkg::word_t'(tx_pin));
      end

      test_name = "tx framing";
      for (int i = 0; i < n_tx; i++) begin
         b = uart_cfg_pkg::byte_t'($random(seed));
         send_byte(b);
         wait_status(uart_reg_pkg::st_txc, 1'b1);
         write_reg(uart_reg_pkg::addr_status, '0);
         read_reg(uart_reg_pkg::addr_status, v);
         check_word("txc cleared", ready_w, v);
         wait_frames(n_sent);
      end

      test_name = "loopback rx";
      write_reg(uart_reg_pkg::addr_status, en_w);
      for (int i = 0; i < n_loop; i++) begin
         b = uart_cfg_pkg::byte_t'($random(seed));
         send_byte(b);
         wait_status(uart_reg_pkg::st_rxc, 1'b1);
         read_reg(uart_reg_pkg::addr_data, v);
         check_byte("rx data", b, v[7:0]);
         check_word("rx data word", uart_reg_pkg::word_t'(b), v);
         write_reg(uart_reg_pkg::addr_status, en_w);
         read_reg(uart_reg_pkg::addr_status, v);
         check_word("rxc cleared", ready_w | en_w, v);
         wait_frames(n_sent);
      end

      test_name = "back-to-back";
      b     = uart_cfg_pkg::byte_t'($random(seed));
      b2    = uart_cfg_pkg::byte_t'($random(seed));
      first = start_q.size();
      send_byte(b);
      send_byte(b2);  // Queued while the first frame is on the line
      wait_status(uart_reg_pkg::st_rxc, 1'b1);
      read_reg(uart_reg_pkg::addr_data, v);
      check_byte("first rx byte", b, v[7:0]);
      write_reg(uart_reg_pkg::addr_status, en_w);
      wait_status(uart_reg_pkg::st_rxc, 1'b1);
      read_reg(uart_reg_pkg::addr_data, v);
      check_byte("second rx byte", b2, v[7:0]);
      last_rx = b2;
      write_reg(uart_reg_pkg::addr_status, en_w);
      wait_frames(n_sent);
      gap = start_q[first + 1] - start_q[first] - frame_bits * uart_cfg_pkg::baud_div;
      if (gap < 0 || gap > uart_cfg_pkg::baud_div) begin
         $display("error [%s] idle gap: expected 0 to %0d cycles, actual %0d",
                  test_name, uart_cfg_pkg::baud_div, gap);
         abort_run();
      end

      test_name = "framing error";
      @(posedge clk);
      loopback <= 1'b0;
      drive_frame(uart_cfg_pkg::byte_t'($random(seed)), 1'b0);
      wait_status(uart_reg_pkg::st_rx_err, 1'b1);
      read_reg(uart_reg_pkg::addr_status, v);
      check_word("status after bad stop", ready_w | en_w | err_w, v);
      read_reg(uart_reg_pkg::addr_data, v);
      check_byte("data kept", last_rx, v[7:0]);

      test_name = "rx disabled";
      write_reg(uart_reg_pkg::addr_status, '0);
      drive_frame(uart_cfg_pkg::byte_t'($random(seed)), 1'b1);
      read_reg(uart_reg_pkg::addr_status, v);
      check_word("status with rx off", ready_w, v);
      read_reg(uart_reg_pkg::addr_data, v);
      check_byte("data kept", last_rx, v[7:0]);

      wait_frames(n_sent);
      if (frame_q.size() != 0 || sent_q.size() != 0) begin
         $display("Frames and written bytes do not match up at the end of the run");
         abort_run();
      end

      $display("Test OK");
      $finish;
   end

endmodule

//--- design/uart.sv
`timescale 1ns/1ps

module uart (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                write_en,
   input  logic                addr,
   input  uart_reg_pkg::word_t write_val,
   output uart_reg_pkg::word_t read_val,
   output logic                tx_pin,
   input  logic                rx_pin
);

   // Status flags
   logic txc;
   logic rxc;
   logic rx_err;
   logic rx_en;

   logic                start_tx;
   logic                in_progress;  // Transmitter owns tx_buffer
   logic                tx_queue_full;
   uart_cfg_pkg::byte_t tx_queue;
   uart_cfg_pkg::byte_t tx_buffer;
   uart_cfg_pkg::byte_t rx_data;

   logic                tx_complete;
   logic                rx_done;
   logic                rx_bad;
   uart_cfg_pkg::byte_t rx_byte;

   logic handoff;
   logic data_wr;
   logic status_wr;

   assign data_wr   = write_en && (addr == uart_reg_pkg::addr_data);
   assign status_wr = write_en && (addr == uart_reg_pkg::addr_status);

   // Queue moves on when the transmitter is idle or in its stop bit
   assign handoff = (tx_complete || !in_progress) && tx_queue_full;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         txc           <= 1'b0;
         rxc           <= 1'b0;
         rx_err        <= 1'b0;
         rx_en         <= 1'b0;
         start_tx      <= 1'b0;
         in_progress   <= 1'b0;
         tx_queue_full <= 1'b0;
      end else begin
         start_tx <= 1'b0;

         if (handoff) begin
            tx_queue_full <= 1'b0;
            start_tx      <= 1'b1;
            in_progress   <= 1'b1;
         end else if (tx_complete) begin
            in_progress <= 1'b0;
         end

         if (data_wr) begin
            tx_queue_full <= 1'b1;  // Overwrites a full queue
         end

         if (status_wr) begin
            txc    <= write_val[uart_reg_pkg::st_txc];
            rx_en  <= write_val[uart_reg_pkg::st_rx_en];
            rxc    <= write_val[uart_reg_pkg::st_rxc];
            rx_err <= write_val[uart_reg_pkg::st_rx_err];
         end

         // Events win over a same-cycle status write
         if (tx_complete) begin
            txc <= 1'b1;
         end
         if (rx_done) begin
            rxc <= 1'b1;
         end
         if (rx_bad) begin
            rx_err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (data_wr) begin
         tx_queue <= write_val[7:0];
      end
      if (handoff) begin
         tx_buffer <= tx_queue;
      end
      if (rx_done) begin
         rx_data <= rx_byte;
      end
   end

   always_comb begin
      read_val = '0;
      if (addr == uart_reg_pkg::addr_status) begin
         read_val[uart_reg_pkg::st_txc]      = txc;
         read_val[uart_reg_pkg::st_tx_ready] = !tx_queue_full;
         read_val[uart_reg_pkg::st_rx_en]    = rx_en;
         read_val[uart_reg_pkg::st_rxc]      = rxc;
         read_val[uart_reg_pkg::st_rx_err]   = rx_err;
      end else begin
         read_val[7:0] = rx_data;
      end
   end

   uart_tx tx_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .start_tx    (start_tx),
      .tx_byte     (tx_buffer),
      .tx_pin      (tx_pin),
      .tx_complete (tx_complete)
   );

   uart_rx rx_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .rx_en   (rx_en),
      .rx_pin  (rx_pin),
      .rx_done (rx_done),
      .rx_err  (rx_bad),
      .rx_byte (rx_byte)
   );

endmodule

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                rx_en,
   input  logic                rx_pin,
   output logic                rx_done,
   output logic                rx_err,
   output uart_cfg_pkg::byte_t rx_byte
);

   uart_cfg_pkg::rx_state_t state;
   uart_cfg_pkg::baud_cnt_t cnt;
   uart_cfg_pkg::bit_idx_t  bit_idx;
   uart_cfg_pkg::byte_t     shreg;
   logic                    bit_end;
   logic                    half_end;

   assign bit_end  = (cnt == uart_cfg_pkg::baud_cnt_t'(uart_cfg_pkg::baud_div - 1));
   assign half_end = (cnt == uart_cfg_pkg::baud_cnt_t'(uart_cfg_pkg::half_baud_div - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= uart_cfg_pkg::rx_off;
         cnt     <= '0;
         bit_idx <= '0;
         rx_done <= 1'b0;
         rx_err  <= 1'b0;
      end else begin
         rx_done <= 1'b0;
         rx_err  <= 1'b0;
         cnt     <= cnt + 1'b1;

         if (!rx_en) begin
            state <= uart_cfg_pkg::rx_off;  // Abandon any frame in flight
            cnt   <= '0;
         end else begin
            case (state)
               uart_cfg_pkg::rx_off: begin
                  state <= uart_cfg_pkg::rx_wait_start;
                  cnt   <= '0;
               end
               uart_cfg_pkg::rx_wait_start: begin
                  cnt <= '0;
                  if (!rx_pin) begin
                     state <= uart_cfg_pkg::rx_start_half;
                  end
               end
               uart_cfg_pkg::rx_start_half: begin
                  if (half_end) begin
                     cnt     <= '0;
                     bit_idx <= '0;
                     if (rx_pin) begin
                        state <= uart_cfg_pkg::rx_wait_start;  // Glitch rather than a start bit
                     end else begin
                        state <= uart_cfg_pkg::rx_data;
                     end
                  end
               end
               uart_cfg_pkg::rx_data: begin
                  if (bit_end) begin
                     cnt     <= '0;
                     bit_idx <= bit_idx + 1'b1;
                     if (bit_idx == 3'd7) begin
                        state <= uart_cfg_pkg::rx_stop;
                     end
                  end
               end
               uart_cfg_pkg::rx_stop: begin
                  if (bit_end) begin
                     cnt     <= '0;
                     state   <= uart_cfg_pkg::rx_wait_start;
                     rx_done <= rx_pin;
                     rx_err  <= !rx_pin;  // Stop bit must be high
                  end
               end
               default: state <= uart_cfg_pkg::rx_off;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == uart_cfg_pkg::rx_data && bit_end) begin
         shreg <= {rx_pin, shreg[7:1]};  // LSB arrives first
      end
      if (rx_en && state == uart_cfg_pkg::rx_stop && bit_end && rx_pin) begin
         rx_byte <= shreg;
      end
   end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                start_tx,
   input  uart_cfg_pkg::byte_t tx_byte,
   output logic                tx_pin,
   output logic                tx_complete
);

   uart_cfg_pkg::tx_state_t state;
   uart_cfg_pkg::baud_cnt_t cnt;
   uart_cfg_pkg::bit_idx_t  bit_idx;
   logic                    pending;  // Start seen while busy
   logic                    bit_end;

   assign bit_end = (cnt == uart_cfg_pkg::baud_cnt_t'(uart_cfg_pkg::baud_div - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= uart_cfg_pkg::tx_idle;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         if (state == uart_cfg_pkg::tx_idle || bit_end) begin
            cnt <= '0;
         end else begin
            cnt <= cnt + 1'b1;
         end

         case (state)
            uart_cfg_pkg::tx_idle: begin
               if (start_tx) begin
                  state <= uart_cfg_pkg::tx_start;
               end
            end
            uart_cfg_pkg::tx_start: begin
               if (bit_end) begin
                  state   <= uart_cfg_pkg::tx_data;
                  bit_idx <= '0;
               end
            end
            uart_cfg_pkg::tx_data: begin
               if (bit_end) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= uart_cfg_pkg::tx_stop;
                  end
               end
            end
            uart_cfg_pkg::tx_stop: begin
               if (bit_end) begin
                  // Next frame follows without an idle bit
                  if (pending || start_tx) begin
                     state <= uart_cfg_pkg::tx_start;
                  end else begin
                     state <= uart_cfg_pkg::tx_idle;
                  end
               end
            end
            default: state <= uart_cfg_pkg::tx_idle;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= 1'b0;
      end else if (state == uart_cfg_pkg::tx_stop && bit_end) begin
         pending <= 1'b0;  // Consumed by the next start bit
      end else if (start_tx && state != uart_cfg_pkg::tx_idle) begin
         pending <= 1'b1;
      end
   end

   assign tx_complete = (state == uart_cfg_pkg::tx_stop) && (cnt == '0);

   always_comb begin
      case (state)
         uart_cfg_pkg::tx_start: tx_pin = 1'b0;
         uart_cfg_pkg::tx_data:  tx_pin = tx_byte[bit_idx];  // LSB first
         default:                tx_pin = 1'b1;  // Idle and stop bit
      endcase
   end

endmodule

//--- design/uart_reg_pkg.sv
package uart_reg_pkg;

   typedef logic [31:0] word_t;

   // One address bit selects the register
   localparam logic addr_data   = 1'b0;
   localparam logic addr_status = 1'b1;

   // Status register bits
   localparam int st_txc      = 0;  // Sticky frame-sent flag
   localparam int st_tx_ready = 1;  // Queue empty
   localparam int st_rx_en    = 2;
   localparam int st_rxc      = 3;  // Sticky byte-received flag
   localparam int st_rx_err   = 4;  // Sticky bad stop bit flag

endpackage

//--- design/uart_cfg_pkg.sv
package uart_cfg_pkg;

   // Clock cycles per serial bit
   localparam int baud_div = 16;
   localparam int half_baud_div = baud_div / 2;  // Start edge to mid-bit

   typedef logic [7:0]  byte_t;
   typedef logic [15:0] baud_cnt_t;
   typedef logic [2:0]  bit_idx_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_t;

   typedef enum logic [2:0] {
      rx_off,
      rx_wait_start,
      rx_start_half,
      rx_data,
      rx_stop
   } rx_state_t;

endpackage
